// File: Bender.yml
package:
  name: alu_pipe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/alu_types_pkg.sv
      - common/alu_op_pkg.sv
      - hw/alu/alu_bitcount.sv
      - hw/alu/alu_arith_stage.sv
      - hw/alu/alu_result_stage.sv
      - hw/alu_pipe.sv
  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_alu_pipe.sv

// File: alu_pipe.f
+incdir+common
+incdir+testbench
common/alu_types_pkg.sv
common/alu_op_pkg.sv
hw/alu/alu_bitcount.sv
hw/alu/alu_arith_stage.sv
hw/alu/alu_result_stage.sv
hw/alu_pipe.sv
testbench/tb_alu_pipe.sv

// File: common/alu_defines.svh
/*
 * Global widths of the integer execute pipeline.
 * Include this header wherever a width macro is needed; the typed
 * views of these widths live in the type and opcode packages.
 */

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Data path width
`define ALU_XLEN 32

// Operation code width, 42 codes in use
`define ALU_OP_W 6

// Transaction id carried alongside each operation
`define ALU_TID_W 4

`endif

// File: common/alu_op_pkg.sv
/*
 * Operation codes accepted by the execute pipeline.
 * Every code below is distinct; values 42 and above are undefined
 * and produce a zero result with the branch bit set.
 */

`include "alu_defines.svh"

`default_nettype none

package alu_op_pkg;

  typedef logic [`ALU_OP_W-1:0] fu_op_t;

  // Add/sub and logic
  localparam fu_op_t ADD       = 6'd0;
  localparam fu_op_t SUB       = 6'd1;
  localparam fu_op_t XORL      = 6'd2;
  localparam fu_op_t ORL       = 6'd3;
  localparam fu_op_t ANDL      = 6'd4;
  localparam fu_op_t XNOR      = 6'd5;
  localparam fu_op_t ORN       = 6'd6;
  localparam fu_op_t ANDN      = 6'd7;
  // Shifts
  localparam fu_op_t SLL       = 6'd8;
  localparam fu_op_t SRL       = 6'd9;
  localparam fu_op_t SRA       = 6'd10;
  // Set less than
  localparam fu_op_t SLTS      = 6'd11;
  localparam fu_op_t SLTU      = 6'd12;
  // Branch compares
  localparam fu_op_t EQ        = 6'd13;
  localparam fu_op_t NE        = 6'd14;
  localparam fu_op_t LTS       = 6'd15;
  localparam fu_op_t LTU       = 6'd16;
  localparam fu_op_t GES       = 6'd17;
  localparam fu_op_t GEU       = 6'd18;
  // Min/max
  localparam fu_op_t MAX       = 6'd19;
  localparam fu_op_t MAXU      = 6'd20;
  localparam fu_op_t MIN       = 6'd21;
  localparam fu_op_t MINU      = 6'd22;
  // Bit counts
  localparam fu_op_t CLZ       = 6'd23;
  localparam fu_op_t CTZ       = 6'd24;
  localparam fu_op_t CPOP      = 6'd25;
  // Sign and zero extends
  localparam fu_op_t SEXTB     = 6'd26;
  localparam fu_op_t SEXTH     = 6'd27;
  localparam fu_op_t ZEXTH     = 6'd28;
  // Rotates and byte operations
  localparam fu_op_t ROL       = 6'd29;
  localparam fu_op_t ROR       = 6'd30;
  localparam fu_op_t ORCB      = 6'd31;
  localparam fu_op_t REV8      = 6'd32;
  // Single-bit operations
  localparam fu_op_t BCLR      = 6'd33;
  localparam fu_op_t BEXT      = 6'd34;
  localparam fu_op_t BINV      = 6'd35;
  localparam fu_op_t BSET      = 6'd36;
  // Shift-add
  localparam fu_op_t SH1ADD    = 6'd37;
  localparam fu_op_t SH2ADD    = 6'd38;
  localparam fu_op_t SH3ADD    = 6'd39;
  // Conditional zero
  localparam fu_op_t CZERO_EQZ = 6'd40;
  localparam fu_op_t CZERO_NEZ = 6'd41;

endpackage

`default_nettype wire

// File: common/alu_types_pkg.sv
/*
 * Data types of the execute pipeline: operands, shift amounts,
 * bit-count results and transaction ids.
 * Modules pull these in with a wildcard import in their header.
 */

`include "alu_defines.svh"

`default_nettype none

package alu_types_pkg;

  // One operand or result word
  typedef logic [`ALU_XLEN-1:0] xlen_t;

  // Shift and rotate amount, low bits of operand b
  typedef logic [4:0] shamt_t;

  // Bit count, wide enough to hold 32
  typedef logic [5:0] bitcnt_t;

  // Transaction id
  typedef logic [`ALU_TID_W-1:0] tid_t;

endpackage

`default_nettype wire

// File: hw/alu/alu_arith_stage.sv
/*
 * First execute stage. Computes the adder result (with optional
 * negation of b and the shift-add pre-shift of a) and the less flag,
 * then registers them together with the operation and its operands
 * for use by the result stage one cycle later.
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_arith_stage
  import alu_types_pkg::*;
  import alu_op_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  fu_op_t op_i,
  input  xlen_t  operand_a_i,
  input  xlen_t  operand_b_i,
  input  tid_t   tid_i,
  output logic   valid_o,
  output fu_op_t op_o,
  output xlen_t  operand_a_o,
  output xlen_t  operand_b_o,
  output tid_t   tid_o,
  output xlen_t  sum_o,
  output logic   less_o
);

  logic                negate_b;
  logic                signed_cmp;
  xlen_t               adder_op_a;
  logic [`ALU_XLEN:0]  adder_in_a;
  logic [`ALU_XLEN:0]  adder_in_b;
  logic [`ALU_XLEN:0]  adder_ext;
  xlen_t               sum;
  logic [`ALU_XLEN:0]  cmp_a;
  logic [`ALU_XLEN:0]  cmp_b;
  logic                less;

  // ----------------------------------------
  // Adder
  // ----------------------------------------

  always_comb begin
    case (op_i)
      SUB, EQ, NE, XNOR, ORN, ANDN: negate_b = 1'b1;
      default:                      negate_b = 1'b0;
    endcase
  end

  // Pre-shift of a for the shift-add group
  always_comb begin
    case (op_i)
      SH1ADD:  adder_op_a = operand_a_i << 1;
      SH2ADD:  adder_op_a = operand_a_i << 2;
      SH3ADD:  adder_op_a = operand_a_i << 3;
      default: adder_op_a = operand_a_i;
    endcase
  end

  // Extra low bit supplies the +1 of the two's complement negation
  assign adder_in_a = {adder_op_a, 1'b1};
  assign adder_in_b = {operand_b_i, 1'b0} ^ {(`ALU_XLEN + 1){negate_b}};
  assign adder_ext  = adder_in_a + adder_in_b;
  assign sum        = adder_ext[`ALU_XLEN:1];

  // ----------------------------------------
  // Comparator
  // ----------------------------------------

  always_comb begin
    case (op_i)
      SLTS, LTS, GES, MAX, MIN: signed_cmp = 1'b1;
      default:                  signed_cmp = 1'b0;
    endcase
  end

  // One extra bit turns an unsigned compare into a signed one
  assign cmp_a = {signed_cmp & operand_a_i[`ALU_XLEN-1], operand_a_i};
  assign cmp_b = {signed_cmp & operand_b_i[`ALU_XLEN-1], operand_b_i};
  assign less  = $signed(cmp_a) < $signed(cmp_b);

  // ----------------------------------------
  // Stage register
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o     <= 1'b0;
      op_o        <= '0;
      operand_a_o <= '0;
      operand_b_o <= '0;
      tid_o       <= '0;
      sum_o       <= '0;
      less_o      <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Data only moves with a valid operation
      if (valid_i) begin
        op_o        <= op_i;
        operand_a_o <= operand_a_i;
        operand_b_o <= operand_b_i;
        tid_o       <= tid_i;
        sum_o       <= sum;
        less_o      <= less;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/alu/alu_bitcount.sv
/*
 * Combinational bit counter for the result stage.
 * Gives the leading-zero count (or trailing-zero count when
 * trailing_i is set) and the population count of one operand.
 * An all-zero operand counts as 32 zeros.
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_bitcount
  import alu_types_pkg::*;
(
  input  xlen_t   operand_i,
  input  logic    trailing_i,
  output bitcnt_t lz_count_o,
  output bitcnt_t pop_count_o
);

  xlen_t operand_rev;
  xlen_t scan_word;

  // Bit reversal turns a trailing count into a leading count
  for (genvar k = 0; k < `ALU_XLEN; k++) begin : gen_rev
    assign operand_rev[k] = operand_i[`ALU_XLEN-1-k];
  end

  assign scan_word = trailing_i ? operand_rev : operand_i;

  // Leading zeros, highest set bit wins
  always_comb begin
    lz_count_o = bitcnt_t'(`ALU_XLEN);
    for (int i = 0; i < `ALU_XLEN; i++) begin
      if (scan_word[i]) begin
        lz_count_o = bitcnt_t'(`ALU_XLEN - 1 - i);
      end
    end
  end

  // Population count on the unreversed operand
  always_comb begin
    pop_count_o = '0;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      pop_count_o = pop_count_o + bitcnt_t'(operand_i[i]);
    end
  end

endmodule

`default_nettype wire

// File: hw/alu/alu_result_stage.sv
/*
 * Second execute stage. Takes the registered operation from the
 * arithmetic stage and forms the final result: shifts, rotates,
 * logic, bit counts, byte and single-bit operations, min/max,
 * extends and conditional zero. Also resolves the branch bit.
 * Result, branch bit and tid are registered on the stage edge.
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_result_stage
  import alu_types_pkg::*;
  import alu_op_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  fu_op_t op_i,
  input  xlen_t  operand_a_i,
  input  xlen_t  operand_b_i,
  input  tid_t   tid_i,
  input  xlen_t  sum_i,
  input  logic   less_i,
  output logic   valid_o,
  output xlen_t  result_o,
  output logic   branch_res_o,
  output tid_t   tid_o
);

  shamt_t             shamt;
  logic               shift_left;
  logic               shift_arith;
  xlen_t              operand_a_rev;
  xlen_t              shift_in;
  logic [`ALU_XLEN:0] shift_in_ext;
  logic [`ALU_XLEN:0] shift_right_res;
  xlen_t              shift_left_res;
  xlen_t              shift_res;
  logic [5:0]         rot_inv;
  xlen_t              rol_res;
  xlen_t              ror_res;
  logic               invert_b;
  xlen_t              logic_b;
  xlen_t              bit_mask;
  xlen_t              orcb_res;
  xlen_t              rev8_res;
  bitcnt_t            lz_count;
  bitcnt_t            pop_count;
  xlen_t              result;
  logic               branch_res;

  assign shamt = operand_b_i[4:0];

  // ----------------------------------------
  // Shifter
  // ----------------------------------------

  assign shift_left  = (op_i == SLL);
  assign shift_arith = (op_i == SRA);

  for (genvar k = 0; k < `ALU_XLEN; k++) begin : gen_shift_rev
    assign operand_a_rev[k]  = operand_a_i[`ALU_XLEN-1-k];
    assign shift_left_res[k] = shift_right_res[`ALU_XLEN-1-k];
  end

  // Left shift is a right shift of the reversed word
  assign shift_in        = shift_left ? operand_a_rev : operand_a_i;
  assign shift_in_ext    = {shift_arith & shift_in[`ALU_XLEN-1], shift_in};
  assign shift_right_res = $unsigned($signed(shift_in_ext) >>> shamt);
  assign shift_res       = shift_left ? shift_left_res : shift_right_res[`ALU_XLEN-1:0];

  // Rotates, amount zero shifts the other half fully out
  assign rot_inv = 6'(`ALU_XLEN) - {1'b0, shamt};
  assign rol_res = (operand_a_i << shamt) | (operand_a_i >> rot_inv);
  assign ror_res = (operand_a_i >> shamt) | (operand_a_i << rot_inv);

  // ----------------------------------------
  // Logic, byte and bit operations
  // ----------------------------------------

  assign invert_b = (op_i == ANDN) | (op_i == ORN) | (op_i == XNOR);
  assign logic_b  = invert_b ? ~operand_b_i : operand_b_i;
  assign bit_mask = xlen_t'(1) << shamt;

  assign orcb_res = {{8{|operand_a_i[31:24]}}, {8{|operand_a_i[23:16]}},
                     {8{|operand_a_i[15:8]}},  {8{|operand_a_i[7:0]}}};
  assign rev8_res = {operand_a_i[7:0], operand_a_i[15:8],
                     operand_a_i[23:16], operand_a_i[31:24]};

  alu_bitcount i_bitcount (
    .operand_i  (operand_a_i),
    .trailing_i (op_i == CTZ),
    .lz_count_o (lz_count),
    .pop_count_o(pop_count)
  );

  // ----------------------------------------
  // Result select and branch
  // ----------------------------------------

  always_comb begin
    case (op_i)
      ADD, SUB, SH1ADD, SH2ADD, SH3ADD: result = sum_i;
      ANDL, ANDN:       result = operand_a_i & logic_b;
      ORL, ORN:         result = operand_a_i | logic_b;
      XORL, XNOR:       result = operand_a_i ^ logic_b;
      SLL, SRL, SRA:    result = shift_res;
      SLTS, SLTU:       result = {{(`ALU_XLEN-1){1'b0}}, less_i};
      MAX, MAXU:        result = less_i ? operand_b_i : operand_a_i;
      MIN, MINU:        result = less_i ? operand_a_i : operand_b_i;
      CLZ, CTZ:         result = {{(`ALU_XLEN-6){1'b0}}, lz_count};
      CPOP:             result = {{(`ALU_XLEN-6){1'b0}}, pop_count};
      SEXTB:            result = {{(`ALU_XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      SEXTH:            result = {{(`ALU_XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      ZEXTH:            result = {{(`ALU_XLEN-16){1'b0}}, operand_a_i[15:0]};
      ROL:              result = rol_res;
      ROR:              result = ror_res;
      ORCB:             result = orcb_res;
      REV8:             result = rev8_res;
      BCLR:             result = operand_a_i & ~bit_mask;
      BEXT:             result = {{(`ALU_XLEN-1){1'b0}}, |(operand_a_i & bit_mask)};
      BINV:             result = operand_a_i ^ bit_mask;
      BSET:             result = operand_a_i | bit_mask;
      CZERO_EQZ:        result = (|operand_b_i) ? operand_a_i : '0;
      CZERO_NEZ:        result = (|operand_b_i) ? '0 : operand_a_i;
      // Branch compares and undefined codes
      default:          result = '0;
    endcase
  end

  // Sum is a minus b for EQ and NE
  always_comb begin
    case (op_i)
      EQ:       branch_res = ~|sum_i;
      NE:       branch_res = |sum_i;
      LTS, LTU: branch_res = less_i;
      GES, GEU: branch_res = ~less_i;
      default:  branch_res = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o      <= 1'b0;
      result_o     <= '0;
      branch_res_o <= 1'b0;
      tid_o        <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o     <= result;
        branch_res_o <= branch_res;
        tid_o        <= tid_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_pipe.sv
/*
 * Two-stage integer execute pipeline, top level.
 * One operation per cycle enters on valid_i; its result, branch bit
 * and tid leave on result_valid_o two clock edges later, in order.
 */

`timescale 1ns/1ps
`default_nettype none

module alu_pipe
  import alu_types_pkg::*;
  import alu_op_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  fu_op_t op_i,
  input  xlen_t  operand_a_i,
  input  xlen_t  operand_b_i,
  input  tid_t   tid_i,
  output logic   result_valid_o,
  output xlen_t  result_o,
  output logic   branch_res_o,
  output tid_t   result_tid_o
);

  // Stage 1 to stage 2
  logic   s1_valid;
  fu_op_t s1_op;
  xlen_t  s1_operand_a;
  xlen_t  s1_operand_b;
  tid_t   s1_tid;
  xlen_t  s1_sum;
  logic   s1_less;

  alu_arith_stage i_arith_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .operand_a_i(operand_a_i),
    .operand_b_i(operand_b_i),
    .tid_i      (tid_i),
    .valid_o    (s1_valid),
    .op_o       (s1_op),
    .operand_a_o(s1_operand_a),
    .operand_b_o(s1_operand_b),
    .tid_o      (s1_tid),
    .sum_o      (s1_sum),
    .less_o     (s1_less)
  );

  alu_result_stage i_result_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (s1_valid),
    .op_i        (s1_op),
    .operand_a_i (s1_operand_a),
    .operand_b_i (s1_operand_b),
    .tid_i       (s1_tid),
    .sum_i       (s1_sum),
    .less_i      (s1_less),
    .valid_o     (result_valid_o),
    .result_o    (result_o),
    .branch_res_o(branch_res_o),
    .tid_o       (result_tid_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_alu_ref.svh
/*
 * Reference model of the execute pipeline for the testbench.
 * Included inside the testbench module after the package imports.
 * Returns {result, branch} for one operation on operands a and b.
 */

`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

function automatic logic [`ALU_XLEN:0] expected_outcome(input fu_op_t op_v,
                                                      input xlen_t a,
                                                      input xlen_t b);
  xlen_t res;
  logic  br;
  logic  lt_s;
  logic  lt_u;
  logic  seen;
  int    idx;
  int    cnt;
  int    i;
  res  = '0;
  br   = 1'b1;
  seen = 1'b0;
  cnt  = 0;
  idx  = int'(b[4:0]);
  lt_s = $signed(a) < $signed(b);
  lt_u = a < b;
  case (op_v)
    ADD:       res = a + b;
    SUB:       res = a - b;
    XORL:      res = a ^ b;
    ORL:       res = a | b;
    ANDL:      res = a & b;
    XNOR:      res = ~(a ^ b);
    ORN:       res = a | ~b;
    ANDN:      res = a & ~b;
    SLL:       res = a << idx;
    SRL:       res = a >> idx;
    SRA:       res = xlen_t'($signed(a) >>> idx);
    SLTS:      res = xlen_t'(lt_s);
    SLTU:      res = xlen_t'(lt_u);
    EQ:        br = (a == b);
    NE:        br = (a != b);
    LTS:       br = lt_s;
    LTU:       br = lt_u;
    GES:       br = !lt_s;
    GEU:       br = !lt_u;
    MAX:       res = lt_s ? b : a;
    MAXU:      res = lt_u ? b : a;
    MIN:       res = lt_s ? a : b;
    MINU:      res = lt_u ? a : b;
    CLZ: begin
      for (i = `ALU_XLEN - 1; i >= 0; i--) begin
        if (a[i]) seen = 1'b1;
        else if (!seen) cnt++;
      end
      res = xlen_t'(cnt);
    end
    CTZ: begin
      for (i = 0; i < `ALU_XLEN; i++) begin
        if (a[i]) seen = 1'b1;
        else if (!seen) cnt++;
      end
      res = xlen_t'(cnt);
    end
    CPOP: begin
      for (i = 0; i < `ALU_XLEN; i++) cnt += a[i];
      res = xlen_t'(cnt);
    end
    SEXTB:     res = xlen_t'($signed(a[7:0]));
    SEXTH:     res = xlen_t'($signed(a[15:0]));
    ZEXTH:     res = {16'h0000, a[15:0]};
    // Amount zero leaves the word unchanged
    ROL:       res = (a << idx) | (a >> ((`ALU_XLEN - idx) % `ALU_XLEN));
    ROR:       res = (a >> idx) | (a << ((`ALU_XLEN - idx) % `ALU_XLEN));
    ORCB:      for (i = 0; i < 4; i++) res[8*i +: 8] = (a[8*i +: 8] != 0) ? 8'hff : 8'h00;
    REV8:      for (i = 0; i < 4; i++) res[8*i +: 8] = a[8*(3-i) +: 8];
    BCLR:      res = a & ~(xlen_t'(1) << idx);
    BEXT:      res = xlen_t'(a[idx]);
    BINV:      res = a ^ (xlen_t'(1) << idx);
    BSET:      res = a | (xlen_t'(1) << idx);
    SH1ADD:    res = (a << 1) + b;
    SH2ADD:    res = (a << 2) + b;
    SH3ADD:    res = (a << 3) + b;
    CZERO_EQZ: res = (b == 0) ? '0 : a;
    CZERO_NEZ: res = (b != 0) ? '0 : a;
    default:   res = '0;
  endcase
  return {res, br};
endfunction

`endif

// File: testbench/tb_alu_pipe.sv
/*
 * Testbench for the two-stage execute pipeline.
 * Runs reset, latency, corner-value and random stream tests; every
 * result is checked in order against the reference model, including
 * its arrival cycle, tid and branch bit.
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module tb_alu_pipe
  import alu_types_pkg::*;
  import alu_op_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_DEFINED  = CZERO_NEZ + 1;
  localparam int NUM_CORNERS  = 8;
  localparam int LATENCY_OPS  = 10;
  localparam int RANDOM_OPS   = 400;
  localparam int MAX_GAP      = 4;
  localparam int DRAIN_CYCLES = 4;
  // Directed sweep covers every defined code plus three undefined ones
  localparam int DIRECTED_OPS = (NUM_DEFINED + 3) * NUM_CORNERS;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + LATENCY_OPS * 4 + DIRECTED_OPS
                                   + RANDOM_OPS * (1 + MAX_GAP) + 20;

  typedef logic [`ALU_TID_W+`ALU_XLEN:0] expect_t;

  logic   clk;
  logic   rst_n;
  logic   valid;
  fu_op_t op;
  xlen_t  operand_a;
  xlen_t  operand_b;
  tid_t   tid;
  logic   result_valid;
  xlen_t  result;
  logic   branch_res;
  tid_t   result_tid;

  expect_t     exp_q[$];
  int          due_q[$];
  int          cycle_cnt = 0;
  int          issued = 0;
  int          checked = 0;
  tid_t        next_tid = '0;
  logic [31:0] lfsr_state = 32'h853c_2bd2;

  // Corner pairs in order of zero, negative a, large unsigned b, shift by 31,
  // equal operands, amount with upper bits, sign bytes with b zero, amount 0
  xlen_t corner_a [NUM_CORNERS] = '{32'h0000_0000, 32'hffff_ffff, 32'h0000_0001,
                                    32'h8000_0000, 32'h1234_5678, 32'hffff_ffff,
                                    32'h0000_8080, 32'h8765_4321};
  xlen_t corner_b [NUM_CORNERS] = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000,
                                    32'h0000_001f, 32'h1234_5678, 32'hffff_ffe3,
                                    32'h0000_0000, 32'h0000_0040};
  fu_op_t latency_ops [LATENCY_OPS] = '{ADD, SUB, SLTS, SLTU, ANDL, ORL, XORL,
                                        ANDN, ORN, XNOR};

  `include "tb_alu_ref.svh"

  alu_pipe DUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .valid_i       (valid),
    .op_i          (op),
    .operand_a_i   (operand_a),
    .operand_b_i   (operand_b),
    .tid_i         (tid),
    .result_valid_o(result_valid),
    .result_o      (result),
    .branch_res_o  (branch_res),
    .result_tid_o  (result_tid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------
  // Random source and drive helpers
  // ----------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return val;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic run_op(input fu_op_t op_v, input xlen_t a_v, input xlen_t b_v);
    @(negedge clk);
    valid     = 1'b1;
    op        = op_v;
    operand_a = a_v;
    operand_b = b_v;
    tid       = next_tid;
    exp_q.push_back({next_tid, expected_outcome(op_v, a_v, b_v)});
    // Result is due two rising edges after this drive
    due_q.push_back(cycle_cnt + 2);
    next_tid = next_tid + 1'b1;
    issued++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle_cycle();
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      waited++;
    end
  endtask

  task automatic run_corners(input fu_op_t op_v);
    int i;
    for (i = 0; i < NUM_CORNERS; i++) run_op(op_v, corner_a[i], corner_b[i]);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin : stimulus
    int     n;
    int     gap;
    fu_op_t rand_op;
    xlen_t  rand_a;
    xlen_t  rand_b;
    clk       = 1'b0;
    rst_n     = 1'b0;
    // Valid stays high in reset so both valid registers must clear
    valid     = 1'b1;
    op        = ADD;
    operand_a = '0;
    operand_b = '0;
    tid       = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    valid = 1'b0;
    repeat (3) idle_cycle();

    // Single operations with the arrival cycle checked per result
    for (n = 0; n < LATENCY_OPS; n++) begin
      run_op(latency_ops[n], 32'h1234_5678, 32'h0f0f_00ff);
      drain();
    end

    // Every defined code over the corner pairs back to back
    for (n = 0; n < NUM_DEFINED; n++) run_corners(fu_op_t'(n));
    run_corners(fu_op_t'(42));
    run_corners(fu_op_t'(55));
    run_corners(fu_op_t'(63));
    drain();

    // Random stream with occasional idle gaps
    for (n = 0; n < RANDOM_OPS; n++) begin
      rand_op = fu_op_t'(random_bits(6) % NUM_DEFINED);
      rand_a  = random_bits(32);
      rand_b  = (random_bits(2) == 0) ? rand_a : random_bits(32);
      run_op(rand_op, rand_a, rand_b);
      if (random_bits(3) == 0) begin
        gap = random_bits(2) + 1;
        repeat (gap) idle_cycle();
      end
    end
    drain();
    repeat (5) idle_cycle();

    if (checked == issued) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Result count wrong: %0d issued, %0d checked", issued, checked);
      $display("SIMULATION FAILED");
      $fatal(1, "result count");
    end
  end

  // ----------------------------------------
  // Checker and watchdog
  // ----------------------------------------

  always @(negedge clk) begin : check_results
    expect_t entry;
    int      due;
    if (!rst_n) begin
      check_value(result_valid, 1'b0, "result_valid_o during reset");
    end else if (result_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected output at %0t ns: a result arrived with nothing issued", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "unexpected output");
      end else begin
        entry = exp_q.pop_front();
        due   = due_q.pop_front();
        check_value(cycle_cnt, due, "result arrival cycle");
        check_value(result_tid, entry[`ALU_TID_W+`ALU_XLEN:`ALU_XLEN+1], "result_tid_o");
        check_value(result, entry[`ALU_XLEN:1], "result_o");
        check_value(branch_res, entry[0], "branch_res_o");
        checked++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish in %0d cycles and hangs", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
